// ==== hdl/macc_pkg.sv ====
/* widths, vector types and sequencer state encoding
   shared by the mac processing element */
package macc_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int DATA_WIDTH  = 16;                         // operand width
  localparam int LEN_WIDTH   = 4;                          // conv length / step index
  localparam int FILT_WIDTH  = 4;                          // filter count / filter index
  localparam int OUT_WIDTH   = 2 * DATA_WIDTH + LEN_WIDTH; // accumulator, 36 bits
  localparam int PAD_LATENCY = 2;                          // index to pad data, cycles

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [DATA_WIDTH-1:0] data_t;  // operand or psum input
  typedef logic [OUT_WIDTH-1:0]  acc_t;   // accumulator and result
  typedef logic [LEN_WIDTH-1:0]  len_t;   // step index, conv length
  typedef logic [FILT_WIDTH-1:0] filt_t;  // filter index, filter count

  // sequencer states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'b000,
    ST_MUL_RUN   = 3'b001,  // one mac step per cycle
    ST_MUL_WAIT  = 3'b011,  // last product still in flight
    ST_MUL_END   = 3'b010,  // filter sum ready
    ST_MUL_CYCLE = 3'b110,  // next filter or back to idle
    ST_ACC_RUN   = 3'b101,  // external plus internal psum per entry
    ST_ACC_END   = 3'b100
  } mac_state_e;

endpackage

// ==== hdl/mac_sequencer.sv ====
`timescale 1ns/1ns

/* state machine and index counters for convolution and accumulate modes,
   decoded into pad enables and step strobes */
module mac_sequencer
  import macc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  len_t  conv_len,         // mac steps per filter
  input  filt_t filter_num,       // filters, or psum entries in acc mode
  input  logic  mac_begin,
  input  logic  acc_begin,
  output logic  mul_enable_flag,  // cnt_a/cnt_b valid for weight and ifmap pads
  output logic  acc_enable_flag,  // cnt_a valid for psum pads
  output len_t  cnt_a,            // step index, or entry index in acc mode
  output filt_t cnt_b,            // filter index
  output logic  add_step,
  output logic  clear_step,
  output logic  sum_step,
  output logic  mac_done,
  output logic  acc_done
);

  mac_state_e state;
  mac_state_e state_nxt;

  logic start_mul;
  logic start_acc;
  logic last_step;
  logic last_filt;
  logic last_entry;

  // a begin only counts when the other one is low
  assign start_mul = mac_begin & ~acc_begin;
  assign start_acc = acc_begin & ~mac_begin;

  assign last_step  = (cnt_a == conv_len - len_t'(1));
  assign last_filt  = (cnt_b == filter_num - filt_t'(1));
  assign last_entry = (filt_t'(cnt_a) == filter_num - filt_t'(1));

  // ----------------------------------------
  // state register and next state
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start_mul) begin
          state_nxt = ST_MUL_RUN;
        end else if (start_acc) begin
          state_nxt = ST_ACC_RUN;
        end
      end
      ST_MUL_RUN: begin
        if (last_step) begin
          state_nxt = ST_MUL_WAIT;
        end
      end
      ST_MUL_WAIT:  state_nxt = ST_MUL_END;
      ST_MUL_END:   state_nxt = ST_MUL_CYCLE;
      ST_MUL_CYCLE: state_nxt = last_filt ? ST_IDLE : ST_MUL_RUN;
      ST_ACC_RUN: begin
        if (last_entry) begin
          state_nxt = ST_ACC_END;
        end
      end
      ST_ACC_END:   state_nxt = ST_IDLE;
      default:      state_nxt = ST_IDLE;
    endcase
  end

  // ----------------------------------------
  // index counters
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_a <= '0;
      cnt_b <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          cnt_a <= '0;
          cnt_b <= '0;
        end
        ST_MUL_RUN: begin
          if (!last_step) begin
            cnt_a <= cnt_a + len_t'(1);  // held on the last step
          end
        end
        ST_MUL_CYCLE: begin
          cnt_a <= '0;
          cnt_b <= last_filt ? '0 : cnt_b + filt_t'(1);
        end
        ST_ACC_RUN: begin
          if (!last_entry) begin
            cnt_a <= cnt_a + len_t'(1);
          end
        end
        ST_ACC_END: begin
          cnt_a <= '0;
        end
        default: begin
          cnt_a <= cnt_a;  // wait and end hold the indices
          cnt_b <= cnt_b;
        end
      endcase
    end
  end

  // ----------------------------------------
  // enables and step strobes
  // ----------------------------------------
  assign mul_enable_flag = (state == ST_MUL_RUN);
  assign acc_enable_flag = (state == ST_ACC_RUN);

  assign add_step   = (state == ST_MUL_RUN);
  assign clear_step = (state == ST_IDLE) || (state == ST_MUL_CYCLE) ||
                      (state == ST_ACC_END);
  assign sum_step   = (state == ST_ACC_RUN);
  assign mac_done   = (state == ST_MUL_END);
  assign acc_done   = (state == ST_ACC_END);  // mul wait decodes to hold

endmodule

// ==== hdl/strobe_align.sv ====
`timescale 1ns/1ns

/* delay line for the five step strobes, matching pad read latency
   plus the operand register stage */
module strobe_align
  import macc_pkg::*;
#(
  parameter int DEPTH = PAD_LATENCY + 1  // 1 or more
)
(
  input  logic clk,
  input  logic rst,
  input  logic add_step,
  input  logic clear_step,
  input  logic sum_step,
  input  logic mac_done,
  input  logic acc_done,
  output logic add_d,
  output logic clear_d,
  output logic sum_d,
  output logic mac_finish_flag,
  output logic acc_finish_flag
);

  localparam int NUM_STROBES = 5;

  logic [NUM_STROBES-1:0] strobe_in;
  logic [NUM_STROBES-1:0] pipe [DEPTH];  // stage 0 nearest the sequencer

  assign strobe_in = {add_step, clear_step, sum_step, mac_done, acc_done};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= strobe_in;
      for (int i = 1; i < DEPTH; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign {add_d, clear_d, sum_d, mac_finish_flag, acc_finish_flag} = pipe[DEPTH-1];

endmodule

// ==== hdl/macc_unit.sv ====
`timescale 1ns/1ns

/* operand registers, unsigned multiplier, psum adder and accumulator,
   plus the psum store flag */
module macc_unit
  import macc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  add_d,            // accumulate registered product
  input  logic  clear_d,          // zero the accumulator
  input  logic  sum_d,            // load external plus internal psum
  input  logic  mac_finish_flag,
  input  data_t weight_in,
  input  data_t ifmap_in,
  input  data_t external_psum,
  input  data_t internal_psum,
  output acc_t  accum_out,
  output logic  psum_store_flag
);

  data_t weight_q;
  data_t ifmap_q;
  data_t ext_psum_q;
  data_t int_psum_q;

  logic [2*DATA_WIDTH-1:0] product;
  acc_t                    psum_sum;
  acc_t                    accum;
  logic                    sum_store_q;  // one cycle after a psum load

  // ----------------------------------------
  // operand registers, loaded every cycle
  // ----------------------------------------
  always_ff @(posedge clk) begin
    weight_q   <= weight_in;
    ifmap_q    <= ifmap_in;
    ext_psum_q <= external_psum;
    int_psum_q <= internal_psum;
  end

  assign product  = weight_q * ifmap_q;                  // unsigned 16x16
  assign psum_sum = acc_t'(ext_psum_q) + acc_t'(int_psum_q);

  // ----------------------------------------
  // accumulator
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      accum       <= '0;
      sum_store_q <= 1'b0;
    end else begin
      sum_store_q <= sum_d;
      if (clear_d) begin
        accum <= '0;
      end else if (add_d) begin
        accum <= accum + acc_t'(product);
      end else if (sum_d) begin
        accum <= psum_sum;
      end
    end
  end

  assign accum_out       = accum;
  assign psum_store_flag = sum_store_q | mac_finish_flag;  // both modes

endmodule

// ==== hdl/macc_control.sv ====
`timescale 1ns/1ns

/* top of the mac processing element, sequencer, strobe delay line
   and mac datapath */
module macc_control
  import macc_pkg::*;
#(
  parameter int PAD_LATENCY = macc_pkg::PAD_LATENCY  // index to pad data, cycles
)
(
  input  logic  clk,
  input  logic  rst,
  input  len_t  conv_len,
  input  filt_t filter_num,
  input  logic  mac_begin,
  input  logic  acc_begin,
  input  data_t weight_in,
  input  data_t ifmap_in,
  input  data_t external_psum,
  input  data_t internal_psum,
  output logic  mul_enable_flag,
  output logic  acc_enable_flag,
  output logic  mac_finish_flag,
  output logic  acc_finish_flag,
  output logic  psum_store_flag,
  output len_t  cnt_a,
  output filt_t cnt_b,
  output acc_t  accum_out
);

  // sequencer strobes, undelayed
  logic add_step;
  logic clear_step;
  logic sum_step;
  logic mac_done;
  logic acc_done;

  // strobes lined up with registered operands
  logic add_d;
  logic clear_d;
  logic sum_d;

  // ----------------------------------------
  // control
  // ----------------------------------------
  mac_sequencer i_sequencer (
    .clk             (clk),
    .rst             (rst),
    .conv_len        (conv_len),
    .filter_num      (filter_num),
    .mac_begin       (mac_begin),
    .acc_begin       (acc_begin),
    .mul_enable_flag (mul_enable_flag),
    .acc_enable_flag (acc_enable_flag),
    .cnt_a           (cnt_a),
    .cnt_b           (cnt_b),
    .add_step        (add_step),
    .clear_step      (clear_step),
    .sum_step        (sum_step),
    .mac_done        (mac_done),
    .acc_done        (acc_done)
  );

  strobe_align #(
    .DEPTH (PAD_LATENCY + 1)  // pads plus operand register
  ) i_strobe_align (
    .clk             (clk),
    .rst             (rst),
    .add_step        (add_step),
    .clear_step      (clear_step),
    .sum_step        (sum_step),
    .mac_done        (mac_done),
    .acc_done        (acc_done),
    .add_d           (add_d),
    .clear_d         (clear_d),
    .sum_d           (sum_d),
    .mac_finish_flag (mac_finish_flag),
    .acc_finish_flag (acc_finish_flag)
  );

  // ----------------------------------------
  // datapath
  // ----------------------------------------
  macc_unit i_macc_unit (
    .clk             (clk),
    .rst             (rst),
    .add_d           (add_d),
    .clear_d         (clear_d),
    .sum_d           (sum_d),
    .mac_finish_flag (mac_finish_flag),
    .weight_in       (weight_in),
    .ifmap_in        (ifmap_in),
    .external_psum   (external_psum),
    .internal_psum   (internal_psum),
    .accum_out       (accum_out),
    .psum_store_flag (psum_store_flag)
  );

endmodule

// ==== verif/tb_checks.svh ====
/* typed compare tasks and error counters for the mac element testbench */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int mismatch_cnt = 0;  // wrong values
int other_cnt    = 0;  // missing, extra or late results

task automatic check_acc(input string name, input acc_t got, input acc_t exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

task automatic check_len(input string name, input len_t got, input len_t exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

task automatic check_filt(input string name, input filt_t got, input filt_t exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

// pulse and cycle counts seen by the monitor
task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    mismatch_cnt++;
    $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

`endif

// ==== verif/tb_macc_control.sv ====
`timescale 1ns/1ns

/* mac element testbench with clock, reset, pad model, result monitor,
   directed tests and watchdog */
module tb_macc_control
  import macc_pkg::*;
;

  localparam int CLK_NS      = 4;
  localparam int IDLE_WAIT   = 12;
  localparam int SINGLE_LEN  = 5 + 3 + PAD_LATENCY + 2 + IDLE_WAIT + 4;
  localparam int MULTI_LEN   = 4 * (3 + 3) + PAD_LATENCY + 2 + IDLE_WAIT + 4;
  localparam int ACC_LEN     = 6 + PAD_LATENCY + 2 + IDLE_WAIT + 4;
  localparam int IGNORE_LEN  = SINGLE_LEN + IDLE_WAIT + 4 + ACC_LEN;
  localparam int RUN_CYCLES  = 8 + 4 + SINGLE_LEN + MULTI_LEN + ACC_LEN + IGNORE_LEN;
  localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_NS + 200;  // doubled plus margin

  logic  clk;
  logic  rst;
  len_t  conv_len;
  filt_t filter_num;
  logic  mac_begin;
  logic  acc_begin;
  data_t weight_in;
  data_t ifmap_in;
  data_t external_psum;
  data_t internal_psum;
  logic  mul_enable_flag;
  logic  acc_enable_flag;
  logic  mac_finish_flag;
  logic  acc_finish_flag;
  logic  psum_store_flag;
  len_t  cnt_a;
  filt_t cnt_b;
  acc_t  accum_out;

  // pad contents with weights per filter and step
  data_t w_mem [256];
  data_t if_mem [16];
  data_t ext_mem [16];
  data_t int_mem [16];
  int    seed = 32'haa97;

  logic [FILT_WIDTH+LEN_WIDTH+1:0] pad_q [$];  // {mul_en, acc_en, cnt_b, cnt_a}
  logic  rec_mul;
  logic  rec_acc;
  filt_t rec_b;
  len_t  rec_a;

  // expected results with one entry per store pulse
  acc_t exp_sum [$];
  logic exp_macfin [$];
  logic exp_accfin [$];
  int   exp_cycle [$];

  int    cyc = 0;
  logic  prev_mul = 1'b0;
  len_t  step_idx = '0;
  filt_t filt_idx = '0;
  int    mul_en_cnt;
  int    acc_en_cnt;
  int    mac_fin_cnt;
  int    acc_fin_cnt;
  int    store_cnt;

  `include "tb_checks.svh"

  macc_control i_dut (
    .clk             (clk),
    .rst             (rst),
    .conv_len        (conv_len),
    .filter_num      (filter_num),
    .mac_begin       (mac_begin),
    .acc_begin       (acc_begin),
    .weight_in       (weight_in),
    .ifmap_in        (ifmap_in),
    .external_psum   (external_psum),
    .internal_psum   (internal_psum),
    .mul_enable_flag (mul_enable_flag),
    .acc_enable_flag (acc_enable_flag),
    .mac_finish_flag (mac_finish_flag),
    .acc_finish_flag (acc_finish_flag),
    .psum_store_flag (psum_store_flag),
    .cnt_a           (cnt_a),
    .cnt_b           (cnt_b),
    .accum_out       (accum_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ----------------------------------------
  // pad model
  // ----------------------------------------
  initial begin
    weight_in     = '0;
    ifmap_in      = '0;
    external_psum = '0;
    internal_psum = '0;
    for (int i = 0; i < 256; i++) begin
      w_mem[i] = data_t'($random(seed));
    end
    for (int i = 0; i < 16; i++) begin
      if_mem[i]  = data_t'($random(seed));
      ext_mem[i] = data_t'($random(seed));
      int_mem[i] = data_t'($random(seed));
    end
    for (int i = 0; i < PAD_LATENCY; i++) begin
      pad_q.push_back('0);
    end
    forever begin
      @(negedge clk);
      pad_q.push_back({mul_enable_flag, acc_enable_flag, cnt_b, cnt_a});
      {rec_mul, rec_acc, rec_b, rec_a} = pad_q.pop_front();  // index from PAD_LATENCY ago
      weight_in     = rec_mul ? w_mem[{rec_b, rec_a}] : 16'hdead;  // junk outside a step
      ifmap_in      = rec_mul ? if_mem[rec_a] : 16'hdead;
      external_psum = rec_acc ? ext_mem[rec_a] : 16'hbeef;
      internal_psum = rec_acc ? int_mem[rec_a] : 16'hbeef;
    end
  end

  // ----------------------------------------
  // monitor
  // ----------------------------------------
  task automatic score_store();
    int due;
    if (exp_sum.size() == 0) begin
      other_cnt++;
      $display("error: psum_store_flag pulse in cycle %0d with no result pending", cyc);
    end else begin
      check_acc("accum_out", accum_out, exp_sum.pop_front());
      check_bit("mac_finish_flag", mac_finish_flag, exp_macfin.pop_front());
      check_bit("acc_finish_flag", acc_finish_flag, exp_accfin.pop_front());
      store_cnt++;
    end
    if (exp_cycle.size() != 0) begin
      due = exp_cycle.pop_front();
      if (due != cyc) begin
        other_cnt++;
        $display("error: psum_store_flag came in cycle %0d, due in cycle %0d", cyc, due);
      end
    end
  endtask

  always @(negedge clk) begin
    cyc++;
    if (mul_enable_flag) begin
      mul_en_cnt++;
      if (!prev_mul) begin
        exp_cycle.push_back(cyc + int'(conv_len) + PAD_LATENCY + 2);  // filter sum due
      end
      check_len("cnt_a", cnt_a, step_idx);
      check_filt("cnt_b", cnt_b, filt_idx);
      step_idx++;
    end else if (acc_enable_flag) begin
      acc_en_cnt++;
      exp_cycle.push_back(cyc + PAD_LATENCY + 2);
      check_len("cnt_a", cnt_a, step_idx);
      step_idx++;
    end else begin
      if (prev_mul) begin
        filt_idx++;
      end
      step_idx = '0;
    end
    prev_mul = mul_enable_flag;
    if (mac_finish_flag) begin
      mac_fin_cnt++;
    end
    if (acc_finish_flag) begin
      acc_fin_cnt++;
    end
    if (psum_store_flag) begin
      score_store();
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic reset_counters();
    mul_en_cnt  = 0;
    acc_en_cnt  = 0;
    mac_fin_cnt = 0;
    acc_fin_cnt = 0;
    store_cnt   = 0;
    filt_idx    = '0;
  endtask

  // unsigned dot product per filter
  task automatic queue_conv_sums(input int len, input int filts);
    acc_t sum;
    for (int f = 0; f < filts; f++) begin
      sum = '0;
      for (int k = 0; k < len; k++) begin
        sum = sum + acc_t'(w_mem[(f << LEN_WIDTH) + k]) * acc_t'(if_mem[k]);
      end
      exp_sum.push_back(sum);
      exp_macfin.push_back(1'b1);
      exp_accfin.push_back(1'b0);
    end
  endtask

  task automatic queue_acc_sums(input int entries);
    for (int k = 0; k < entries; k++) begin
      exp_sum.push_back(acc_t'(ext_mem[k]) + acc_t'(int_mem[k]));
      exp_macfin.push_back(1'b0);
      exp_accfin.push_back(k == entries - 1);  // finish with the last entry
    end
  endtask

  task automatic pulse_begin(input logic mac, input logic acc);
    @(negedge clk);
    mac_begin = mac;
    acc_begin = acc;
    @(negedge clk);
    mac_begin = 1'b0;
    acc_begin = 1'b0;
  endtask

  task automatic wait_results(input int limit);
    int n;
    n = 0;
    while (exp_sum.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_sum.size() != 0) begin
      other_cnt++;
      $display("error: %0d results still missing after %0d cycles", exp_sum.size(), limit);
    end
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_bit("mul_enable_flag", mul_enable_flag, 1'b0);
      check_bit("acc_enable_flag", acc_enable_flag, 1'b0);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic reset_state_test();
    @(negedge clk);
    check_bit("mul_enable_flag", mul_enable_flag, 1'b0);
    check_bit("acc_enable_flag", acc_enable_flag, 1'b0);
    check_bit("mac_finish_flag", mac_finish_flag, 1'b0);
    check_bit("acc_finish_flag", acc_finish_flag, 1'b0);
    check_bit("psum_store_flag", psum_store_flag, 1'b0);
    check_len("cnt_a", cnt_a, '0);
    check_filt("cnt_b", cnt_b, '0);
    check_acc("accum_out", accum_out, '0);
  endtask

  task automatic single_filter_test();
    conv_len   = 4'd5;
    filter_num = 4'd1;
    reset_counters();
    queue_conv_sums(5, 1);
    pulse_begin(1'b1, 1'b0);
    wait_results(2 * SINGLE_LEN);
    expect_idle(IDLE_WAIT);
    check_count("mul_enable cycles", mul_en_cnt, 5);
    check_count("mac_finish pulses", mac_fin_cnt, 1);
  endtask

  task automatic multi_filter_test();
    conv_len   = 4'd3;
    filter_num = 4'd4;
    reset_counters();
    queue_conv_sums(3, 4);
    pulse_begin(1'b1, 1'b0);
    wait_results(2 * MULTI_LEN);
    expect_idle(IDLE_WAIT);
    check_count("mul_enable cycles", mul_en_cnt, 12);
    check_count("mac_finish pulses", mac_fin_cnt, 4);
  endtask

  task automatic accumulate_test();
    filter_num = 4'd6;
    reset_counters();
    queue_acc_sums(6);
    pulse_begin(1'b0, 1'b1);
    wait_results(2 * ACC_LEN);
    expect_idle(IDLE_WAIT);
    check_count("acc_enable cycles", acc_en_cnt, 6);
    check_count("psum_store pulses", store_cnt, 6);
    check_count("acc_finish pulses", acc_fin_cnt, 1);
  endtask

  task automatic ignored_begin_test();
    // begins while a convolution runs
    conv_len   = 4'd5;
    filter_num = 4'd1;
    reset_counters();
    queue_conv_sums(5, 1);
    pulse_begin(1'b1, 1'b0);
    pulse_begin(1'b1, 1'b0);
    pulse_begin(1'b0, 1'b1);
    wait_results(2 * SINGLE_LEN);
    expect_idle(IDLE_WAIT);
    check_count("mul_enable cycles", mul_en_cnt, 5);
    check_count("acc_enable cycles", acc_en_cnt, 0);
    check_count("mac_finish pulses", mac_fin_cnt, 1);
    // both begins together in idle
    reset_counters();
    pulse_begin(1'b1, 1'b1);
    expect_idle(IDLE_WAIT);
    check_count("mul_enable cycles", mul_en_cnt, 0);
    check_count("acc_enable cycles", acc_en_cnt, 0);
    // mac begin during an accumulate run
    filter_num = 4'd6;
    reset_counters();
    queue_acc_sums(6);
    pulse_begin(1'b0, 1'b1);
    pulse_begin(1'b1, 1'b0);
    wait_results(2 * ACC_LEN);
    expect_idle(IDLE_WAIT);
    check_count("mul_enable cycles", mul_en_cnt, 0);
    check_count("acc_enable cycles", acc_en_cnt, 6);
    check_count("psum_store pulses", store_cnt, 6);
    check_count("acc_finish pulses", acc_fin_cnt, 1);
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    rst        = 1'b1;
    conv_len   = 4'd1;
    filter_num = 4'd1;
    mac_begin  = 1'b0;
    acc_begin  = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    reset_state_test();
    single_filter_test();
    multi_filter_test();
    accumulate_test();
    ignored_begin_test();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("error: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verif
hdl/macc_pkg.sv
hdl/mac_sequencer.sv
hdl/strobe_align.sv
hdl/macc_unit.sv
hdl/macc_control.sv
verif/tb_macc_control.sv

// ==== run.sh ====
#!/bin/sh
# build the mac element testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_macc_control -f files.f -o sim_macc || exit 1
./obj_dir/sim_macc > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
